//--- src/com_config_pkg.sv
// Config write path package: op codes, command layout, payload views, readback select

package com_config_pkg;

  // --------------------------------------------------
  // Operation codes, top byte of sw_write32_0
  // --------------------------------------------------
  typedef enum logic [7:0] {
    OP_RESET        = 8'h01,  // Clear all config registers
    OP_CFG_STATIC_0 = 8'h10,  // Load static word 0
    OP_CFG_STATIC_1 = 8'h11,  // Load static word 1
    OP_CFG_ARRAY_0  = 8'h20,  // Write one entry of array 0
    OP_CFG_ARRAY_1  = 8'h21   // Write one entry of array 1
  } op_code_e;

  // Array entry view of the payload
  typedef struct packed {
    logic [7:0]  idx;  // Entry index, bits 23:16
    logic [15:0] val;  // Entry value, bits 15:0
  } cfg_entry_t;

  // Low three bytes of a command, decoded one of two ways
  typedef union packed {
    logic [23:0] static_val;  // Whole word for static targets
    cfg_entry_t  entry;       // Index plus value for array targets
  } cfg_payload_u;

  // Software command word
  typedef struct packed {
    op_code_e     op;
    cfg_payload_u payload;
  } sw_cmd_t;

  // --------------------------------------------------
  // Decoded operation pulses, at most one high
  // --------------------------------------------------
  typedef struct packed {
    logic w_reset;
    logic w_static_0;
    logic w_static_1;
    logic w_array_0;
    logic w_array_1;
  } cfg_op_t;

  // Readback select
  typedef struct packed {
    logic [1:0] target;  // 0 static 0, 1 static 1, 2 array 0, 3 array 1
    logic [7:0] idx;     // Entry index, array targets only
  } rd_sel_t;

  // Entries per config array
  localparam int CFG_ARRAY_DEPTH_DEFAULT = 256;

endpackage

//--- src/com_op_decoder.sv
// Command decoder: registers the software command and emits one operation pulse

`timescale 1ns/100ps

module com_op_decoder (
  input  logic                       fw_clk_100,       // 100 MHz FW clock
  input  logic                       fw_rst_n,         // Async reset, active low
  input  com_config_pkg::sw_cmd_t    sw_write32_0,     // Command word from SW
  input  logic                       sw_write_strobe,  // One cycle, no back-pressure
  output com_config_pkg::cfg_op_t    cfg_op,           // Registered pulses
  output com_config_pkg::cfg_payload_u cfg_payload,    // Payload held with pulse
  output logic                       op_illegal        // Unknown op code seen
);

  com_config_pkg::cfg_op_t op_next;
  logic                    illegal_next;

  // --------------------------------------------------
  // Op code compare
  // --------------------------------------------------
  always_comb begin
    op_next      = '0;
    illegal_next = 1'b0;
    if (sw_write_strobe) begin
      case (sw_write32_0.op)
        com_config_pkg::OP_RESET:        op_next.w_reset    = 1'b1;
        com_config_pkg::OP_CFG_STATIC_0: op_next.w_static_0 = 1'b1;
        com_config_pkg::OP_CFG_STATIC_1: op_next.w_static_1 = 1'b1;
        com_config_pkg::OP_CFG_ARRAY_0:  op_next.w_array_0  = 1'b1;
        com_config_pkg::OP_CFG_ARRAY_1:  op_next.w_array_1  = 1'b1;
        default:                         illegal_next       = 1'b1;  // Flag, no pulse
      endcase
    end
  end

  // Pulse stage, low again next cycle unless another strobe
  always_ff @(posedge fw_clk_100 or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      cfg_op     <= '0;
      op_illegal <= 1'b0;
    end else begin
      cfg_op     <= op_next;
      op_illegal <= illegal_next;
    end
  end

  // Payload rides along with the pulse
  // Only looked at while a pulse is high
  always_ff @(posedge fw_clk_100) begin
    if (sw_write_strobe) begin
      cfg_payload <= sw_write32_0.payload;
    end
  end

endmodule

//--- src/com_config_write_regs.sv
// Config register block: two static words and two entry arrays, written by op pulses

`timescale 1ns/100ps

module com_config_write_regs #(
  parameter int ARRAY_DEPTH = com_config_pkg::CFG_ARRAY_DEPTH_DEFAULT  // Entries per array
) (
  input  logic                                fw_clk_100,   // 100 MHz FW clock
  input  logic                                fw_rst_n,     // Async reset, active low
  input  com_config_pkg::cfg_op_t             cfg_op,       // Decoded pulses
  input  com_config_pkg::cfg_payload_u        cfg_payload,  // Static or entry view
  output logic [23:0]                         w_cfg_static_0_reg,
  output logic [23:0]                         w_cfg_static_1_reg,
  output logic [ARRAY_DEPTH-1:0][15:0]        w_cfg_array_0_reg,
  output logic [ARRAY_DEPTH-1:0][15:0]        w_cfg_array_1_reg
);

  logic arr_idx_ok;  // Entry index inside the array
  logic arr_0_we;
  logic arr_1_we;

  // Drop writes past the end of the array
  assign arr_idx_ok = (int'(cfg_payload.entry.idx) < ARRAY_DEPTH);
  assign arr_0_we   = cfg_op.w_array_0 && arr_idx_ok;
  assign arr_1_we   = cfg_op.w_array_1 && arr_idx_ok;

  // --------------------------------------------------
  // Static words
  // --------------------------------------------------
  always_ff @(posedge fw_clk_100 or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      w_cfg_static_0_reg <= '0;
      w_cfg_static_1_reg <= '0;
    end else if (cfg_op.w_reset) begin  // Reset op wins over any write
      w_cfg_static_0_reg <= '0;
      w_cfg_static_1_reg <= '0;
    end else begin
      if (cfg_op.w_static_0) begin
        w_cfg_static_0_reg <= cfg_payload.static_val;  // Whole 24 bit view
      end
      if (cfg_op.w_static_1) begin
        w_cfg_static_1_reg <= cfg_payload.static_val;
      end
    end
  end

  // --------------------------------------------------
  // Entry arrays
  // --------------------------------------------------
  // One entry per write, index from the upper payload byte
  always_ff @(posedge fw_clk_100 or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      w_cfg_array_0_reg <= '0;
      w_cfg_array_1_reg <= '0;
    end else if (cfg_op.w_reset) begin
      w_cfg_array_0_reg <= '0;  // Clear all entries
      w_cfg_array_1_reg <= '0;
    end else begin
      if (arr_0_we) begin
        w_cfg_array_0_reg[cfg_payload.entry.idx] <= cfg_payload.entry.val;
      end
      if (arr_1_we) begin
        w_cfg_array_1_reg[cfg_payload.entry.idx] <= cfg_payload.entry.val;
      end
    end
  end

  // Arrays are driven straight to downstream firmware
  // Latency from pulse to output is one edge

endmodule

//--- src/com_config_read_mux.sv
// Readback selector: picks a static word or array entry and registers it as a 32-bit word

`timescale 1ns/100ps

module com_config_read_mux #(
  parameter int ARRAY_DEPTH = com_config_pkg::CFG_ARRAY_DEPTH_DEFAULT  // Entries per array
) (
  input  logic                          fw_clk_100,   // 100 MHz FW clock
  input  logic                          fw_rst_n,     // Async reset, active low
  input  com_config_pkg::rd_sel_t       sw_read_sel,  // Sampled every cycle
  input  logic [23:0]                   w_cfg_static_0_reg,
  input  logic [23:0]                   w_cfg_static_1_reg,
  input  logic [ARRAY_DEPTH-1:0][15:0]  w_cfg_array_0_reg,
  input  logic [ARRAY_DEPTH-1:0][15:0]  w_cfg_array_1_reg,
  output logic [31:0]                   sw_read32_0   // Readback word
);

  logic        rd_idx_ok;   // Index inside the array
  logic [15:0] entry_val;   // Selected array entry
  logic [23:0] static_val;  // Selected static word
  logic [31:0] rd_word;     // Formatted, before the register

  assign rd_idx_ok = (int'(sw_read_sel.idx) < ARRAY_DEPTH);

  // --------------------------------------------------
  // Select
  // --------------------------------------------------
  // target bit 0 picks word/array 0 or 1, bit 1 picks array over static
  always_comb begin
    entry_val = 16'h0000;  // Out of range reads as zero data
    if (rd_idx_ok) begin
      entry_val = sw_read_sel.target[0] ? w_cfg_array_1_reg[sw_read_sel.idx]
                                        : w_cfg_array_0_reg[sw_read_sel.idx];
    end
  end

  assign static_val = sw_read_sel.target[0] ? w_cfg_static_1_reg : w_cfg_static_0_reg;

  // Array reads echo the index in byte 2
  assign rd_word = sw_read_sel.target[1] ? {8'h00, sw_read_sel.idx, entry_val}
                                         : {8'h00, static_val};

  // Stable word one cycle after the select
  always_ff @(posedge fw_clk_100 or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      sw_read32_0 <= '0;
    end else begin
      sw_read32_0 <= rd_word;
    end
  end

endmodule

//--- src/com_config_top.sv
// Config write path top: decoder, register block and readback selector

`timescale 1ns/100ps

module com_config_top #(
  parameter int ARRAY_DEPTH = com_config_pkg::CFG_ARRAY_DEPTH_DEFAULT  // Entries per array
) (
  input  logic                          fw_clk_100,       // 100 MHz FW clock
  input  logic                          fw_rst_n,         // Async reset, active low
  // SW write side
  input  com_config_pkg::sw_cmd_t       sw_write32_0,     // Op code and payload
  input  logic                          sw_write_strobe,  // One cycle per command
  // SW read side
  input  com_config_pkg::rd_sel_t       sw_read_sel,
  output logic [31:0]                   sw_read32_0,
  output logic                          op_illegal,       // Unknown op code pulse
  // Config out to firmware
  output logic [23:0]                   w_cfg_static_0_reg,
  output logic [23:0]                   w_cfg_static_1_reg,
  output logic [ARRAY_DEPTH-1:0][15:0]  w_cfg_array_0_reg,
  output logic [ARRAY_DEPTH-1:0][15:0]  w_cfg_array_1_reg
);

  com_config_pkg::cfg_op_t      cfg_op;       // Decoder to registers
  com_config_pkg::cfg_payload_u cfg_payload;

  // --------------------------------------------------
  // Decode, cycle N+1
  // --------------------------------------------------
  com_op_decoder u_op_decoder (
    .fw_clk_100      (fw_clk_100),
    .fw_rst_n        (fw_rst_n),
    .sw_write32_0    (sw_write32_0),
    .sw_write_strobe (sw_write_strobe),
    .cfg_op          (cfg_op),
    .cfg_payload     (cfg_payload),
    .op_illegal      (op_illegal)
  );

  // Register update at edge N+2
  com_config_write_regs #(
    .ARRAY_DEPTH (ARRAY_DEPTH)
  ) u_write_regs (
    .fw_clk_100         (fw_clk_100),
    .fw_rst_n           (fw_rst_n),
    .cfg_op             (cfg_op),
    .cfg_payload        (cfg_payload),
    .w_cfg_static_0_reg (w_cfg_static_0_reg),
    .w_cfg_static_1_reg (w_cfg_static_1_reg),
    .w_cfg_array_0_reg  (w_cfg_array_0_reg),
    .w_cfg_array_1_reg  (w_cfg_array_1_reg)
  );

  // Readback, one cycle behind the select
  com_config_read_mux #(
    .ARRAY_DEPTH (ARRAY_DEPTH)
  ) u_read_mux (
    .fw_clk_100         (fw_clk_100),
    .fw_rst_n           (fw_rst_n),
    .sw_read_sel        (sw_read_sel),
    .w_cfg_static_0_reg (w_cfg_static_0_reg),
    .w_cfg_static_1_reg (w_cfg_static_1_reg),
    .w_cfg_array_0_reg  (w_cfg_array_0_reg),
    .w_cfg_array_1_reg  (w_cfg_array_1_reg),
    .sw_read32_0        (sw_read32_0)
  );

endmodule

//--- test/tb_clock_gen.sv
// Testbench clock and reset source: 100 MHz clock, reset held low for 16 cycles

`timescale 1ns/100ps

module tb_clock_gen (
  output logic fw_clk_100,  // 10 ns period
  output logic fw_rst_n     // Active low
);

  initial begin
    fw_clk_100 = 1'b0;
    forever #5 fw_clk_100 = ~fw_clk_100;
  end

  // Clean falling edge so async reset fires
  initial begin
    fw_rst_n = 1'b1;
    #1;
    fw_rst_n = 1'b0;
    repeat (16) @(posedge fw_clk_100);
    #1;
    fw_rst_n = 1'b1;  // Release off the edge
  end

endmodule

//--- test/com_config_checker.sv
// Assertion checker for the config write path, bound into the top level

`timescale 1ns/100ps

module com_config_checker (
  input logic                    fw_clk_100,
  input logic                    fw_rst_n,
  input com_config_pkg::sw_cmd_t sw_write32_0,
  input logic                    sw_write_strobe,
  input com_config_pkg::cfg_op_t cfg_op,
  input logic                    op_illegal
);

  int   fail_cnt = 0;  // Read by the testbench at the end
  logic legal_cmd;

  assign legal_cmd = sw_write32_0.op inside {com_config_pkg::OP_RESET,
                                             com_config_pkg::OP_CFG_STATIC_0,
                                             com_config_pkg::OP_CFG_STATIC_1,
                                             com_config_pkg::OP_CFG_ARRAY_0,
                                             com_config_pkg::OP_CFG_ARRAY_1};

  // --------------------------------------------------
  // Pulse shape
  // --------------------------------------------------
  a_op_onehot0: assert property (@(posedge fw_clk_100) disable iff (!fw_rst_n)
                                 $onehot0(cfg_op))
    else begin
      fail_cnt++;
      $error("cfg_op has more than one pulse high");
    end

  a_no_overlap: assert property (@(posedge fw_clk_100) disable iff (!fw_rst_n)
                                 !(op_illegal && (|cfg_op)))
    else begin
      fail_cnt++;
      $error("op_illegal high together with a cfg_op pulse");
    end

  // Legal command gives exactly one pulse next cycle
  a_legal_pulse: assert property (@(posedge fw_clk_100) disable iff (!fw_rst_n)
                                  (sw_write_strobe && legal_cmd) |=> $onehot(cfg_op))
    else begin
      fail_cnt++;
      $error("Legal command not followed by exactly one cfg_op pulse");
    end

  a_reset_quiet: assert property (@(posedge fw_clk_100) !fw_rst_n |-> (cfg_op == '0))
    else begin
      fail_cnt++;
      $error("cfg_op not zero during reset");
    end

endmodule

bind com_config_top com_config_checker u_checker (
  .fw_clk_100      (fw_clk_100),
  .fw_rst_n        (fw_rst_n),
  .sw_write32_0    (sw_write32_0),
  .sw_write_strobe (sw_write_strobe),
  .cfg_op          (cfg_op),
  .op_illegal      (op_illegal)
);

//--- test/tb_com_config.sv
// Table driven testbench for the config write path, checked against a register model

`timescale 1ns/100ps

module tb_com_config;

  localparam int DEPTH       = 64;  // Small so out of range indexes exist
  localparam int MAX_ENTRIES = 64;

  logic                    fw_clk_100;
  logic                    fw_rst_n;
  com_config_pkg::sw_cmd_t sw_write32_0;
  logic                    sw_write_strobe;
  com_config_pkg::rd_sel_t sw_read_sel;
  logic [31:0]             sw_read32_0;
  logic                    op_illegal;
  logic [23:0]             w_cfg_static_0_reg;
  logic [23:0]             w_cfg_static_1_reg;
  logic [DEPTH-1:0][15:0]  w_cfg_array_0_reg;
  logic [DEPTH-1:0][15:0]  w_cfg_array_1_reg;

  // Stimulus table, one column per array
  logic                    tbl_wr  [MAX_ENTRIES];  // Entry strobes a write
  com_config_pkg::sw_cmd_t tbl_cmd [MAX_ENTRIES];
  com_config_pkg::rd_sel_t tbl_sel [MAX_ENTRIES];
  logic [31:0]             tbl_exp [MAX_ENTRIES];  // Expected readback
  logic                    tbl_ill [MAX_ENTRIES];  // Expected op_illegal pulse
  int                      n_entries = 0;

  // Register model
  logic [23:0] m_static [2];
  logic [15:0] m_arr0 [DEPTH];
  logic [15:0] m_arr1 [DEPTH];

  int err_cnt     = 0;
  int test_pass   = 0;
  int test_fail   = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 1000000;  // Replaced once the table is built

  tb_clock_gen u_clock_gen (
    .fw_clk_100 (fw_clk_100),
    .fw_rst_n   (fw_rst_n)
  );

  com_config_top #(
    .ARRAY_DEPTH (DEPTH)
  ) dut0 (
    .fw_clk_100         (fw_clk_100),
    .fw_rst_n           (fw_rst_n),
    .sw_write32_0       (sw_write32_0),
    .sw_write_strobe    (sw_write_strobe),
    .sw_read_sel        (sw_read_sel),
    .sw_read32_0        (sw_read32_0),
    .op_illegal         (op_illegal),
    .w_cfg_static_0_reg (w_cfg_static_0_reg),
    .w_cfg_static_1_reg (w_cfg_static_1_reg),
    .w_cfg_array_0_reg  (w_cfg_array_0_reg),
    .w_cfg_array_1_reg  (w_cfg_array_1_reg)
  );

  // --------------------------------------------------
  // Model
  // --------------------------------------------------
  function automatic void model_clear();
    m_static[0] = '0;
    m_static[1] = '0;
    for (int i = 0; i < DEPTH; i++) begin
      m_arr0[i] = '0;
      m_arr1[i] = '0;
    end
  endfunction

  function automatic logic is_legal(input logic [7:0] op);
    return op inside {com_config_pkg::OP_RESET, com_config_pkg::OP_CFG_STATIC_0,
                      com_config_pkg::OP_CFG_STATIC_1, com_config_pkg::OP_CFG_ARRAY_0,
                      com_config_pkg::OP_CFG_ARRAY_1};
  endfunction

  function automatic void model_apply(input logic [7:0] op, input logic [23:0] pl);
    int idx;
    idx = int'(pl[23:16]);
    case (op)
      com_config_pkg::OP_RESET:        model_clear();
      com_config_pkg::OP_CFG_STATIC_0: m_static[0] = pl;
      com_config_pkg::OP_CFG_STATIC_1: m_static[1] = pl;
      com_config_pkg::OP_CFG_ARRAY_0: begin
        if (idx < DEPTH) m_arr0[idx] = pl[15:0];  // Out of range dropped
      end
      com_config_pkg::OP_CFG_ARRAY_1: begin
        if (idx < DEPTH) m_arr1[idx] = pl[15:0];
      end
      default: ;  // Illegal code, no change
    endcase
  endfunction

  function automatic logic [31:0] model_read(input com_config_pkg::rd_sel_t sel);
    int          idx;
    logic [15:0] val;
    idx = int'(sel.idx);
    val = 16'h0000;
    if (sel.target < 2'd2) return {8'h00, m_static[sel.target[0]]};
    if (idx < DEPTH) val = sel.target[0] ? m_arr1[idx] : m_arr0[idx];
    return {8'h00, sel.idx, val};
  endfunction

  // Append one row, expected value from the model state so far
  function automatic void add_entry(input logic wr, input logic [7:0] op,
                                    input logic [23:0] pl, input logic [1:0] target,
                                    input logic [7:0] idx);
    com_config_pkg::sw_cmd_t cmd;
    com_config_pkg::rd_sel_t sel;
    cmd.op                 = com_config_pkg::op_code_e'(op);
    cmd.payload.static_val = pl;
    sel.target             = target;
    sel.idx                = idx;
    tbl_wr[n_entries]      = wr;
    tbl_cmd[n_entries]     = cmd;
    tbl_sel[n_entries]     = sel;
    tbl_ill[n_entries]     = wr && !is_legal(op);
    if (wr) model_apply(op, pl);
    tbl_exp[n_entries] = model_read(sel);
    n_entries++;
  endfunction

  // --------------------------------------------------
  // Table contents
  // --------------------------------------------------
  function automatic void build_table();
    logic [7:0] idx;
    logic [7:0] last_idx;
    last_idx = 8'h00;
    // Reset state, reads only
    add_entry(1'b0, 8'h00, 24'h0, 2'd0, 8'h00);
    add_entry(1'b0, 8'h00, 24'h0, 2'd1, 8'h00);
    add_entry(1'b0, 8'h00, 24'h0, 2'd2, 8'h00);
    add_entry(1'b0, 8'h00, 24'h0, 2'd2, 8'd63);
    add_entry(1'b0, 8'h00, 24'h0, 2'd3, 8'd17);
    add_entry(1'b0, 8'h00, 24'h0, 2'd3, 8'd200);
    // Static words, each write checked against the other word too
    add_entry(1'b1, com_config_pkg::OP_CFG_STATIC_0, 24'($urandom), 2'd0, 8'h00);
    add_entry(1'b1, com_config_pkg::OP_CFG_STATIC_1, 24'($urandom), 2'd0, 8'h00);
    add_entry(1'b0, 8'h00, 24'h0, 2'd1, 8'h00);
    add_entry(1'b1, com_config_pkg::OP_CFG_STATIC_0, 24'($urandom), 2'd1, 8'h00);
    add_entry(1'b0, 8'h00, 24'h0, 2'd0, 8'h00);
    // Same index in both arrays, then array 0 again
    for (int k = 0; k < 4; k++) begin
      idx = 8'($urandom % DEPTH);
      add_entry(1'b1, com_config_pkg::OP_CFG_ARRAY_0, {idx, 16'($urandom)}, 2'd2, idx);
      add_entry(1'b1, com_config_pkg::OP_CFG_ARRAY_1, {idx, 16'($urandom)}, 2'd3, idx);
      add_entry(1'b0, 8'h00, 24'h0, 2'd2, idx);
      last_idx = idx;
    end
    // Out of range writes
    idx = 8'(DEPTH + ($urandom % (256 - DEPTH)));
    add_entry(1'b1, com_config_pkg::OP_CFG_ARRAY_0, {idx, 16'hbeef}, 2'd2, idx);
    add_entry(1'b1, com_config_pkg::OP_CFG_ARRAY_1, {8'hff, 16'h1234}, 2'd3, 8'hff);
    add_entry(1'b1, com_config_pkg::OP_CFG_ARRAY_0, {8'd64, 16'h5a5a}, 2'd2, 8'd64);
    // Illegal codes
    add_entry(1'b1, 8'h33, 24'($urandom), 2'd0, 8'h00);
    add_entry(1'b1, 8'hff, {last_idx, 16'hdead}, 2'd2, last_idx);
    add_entry(1'b1, 8'h00, 24'($urandom), 2'd1, 8'h00);
    // Reset op clears everything written so far
    add_entry(1'b1, com_config_pkg::OP_RESET, 24'($urandom), 2'd0, 8'h00);
    add_entry(1'b0, 8'h00, 24'h0, 2'd1, 8'h00);
    add_entry(1'b0, 8'h00, 24'h0, 2'd2, last_idx);
    add_entry(1'b0, 8'h00, 24'h0, 2'd3, last_idx);
  endfunction

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  task automatic check_illegal(input logic exp);
    if (op_illegal !== exp) begin
      $display("Mismatch at %0t: op_illegal expected %b got %b", $time, exp, op_illegal);
      err_cnt++;
    end
  endtask

  task automatic check_read(input logic [31:0] exp);
    if (sw_read32_0 !== exp) begin
      $display("Mismatch at %0t: sw_read32_0 expected %h got %h", $time, exp, sw_read32_0);
      err_cnt++;
    end
  endtask

  // Config outputs to firmware against the model
  task automatic check_outputs();
    if (w_cfg_static_0_reg !== m_static[0]) begin
      $display("Mismatch at %0t: w_cfg_static_0_reg expected %h got %h", $time,
               m_static[0], w_cfg_static_0_reg);
      err_cnt++;
    end
    if (w_cfg_static_1_reg !== m_static[1]) begin
      $display("Mismatch at %0t: w_cfg_static_1_reg expected %h got %h", $time,
               m_static[1], w_cfg_static_1_reg);
      err_cnt++;
    end
    for (int i = 0; i < DEPTH; i++) begin
      if (w_cfg_array_0_reg[i] !== m_arr0[i]) begin
        $display("Mismatch at %0t: w_cfg_array_0_reg[%0d] expected %h got %h", $time, i,
                 m_arr0[i], w_cfg_array_0_reg[i]);
        err_cnt++;
      end
      if (w_cfg_array_1_reg[i] !== m_arr1[i]) begin
        $display("Mismatch at %0t: w_cfg_array_1_reg[%0d] expected %h got %h", $time, i,
                 m_arr1[i], w_cfg_array_1_reg[i]);
        err_cnt++;
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      test_pass++;
      $display("Test %s passed", name);
    end else begin
      test_fail++;
      $display("Test %s failed", name);
    end
  endtask

  // Strobe, three cycles, select, one cycle, compare
  task automatic run_entry(input int i);
    int errs_before;
    errs_before = err_cnt;
    if (tbl_wr[i]) begin
      sw_write32_0    = tbl_cmd[i];
      sw_write_strobe = 1'b1;
    end
    @(posedge fw_clk_100);  // Edge N
    #1;
    sw_write_strobe = 1'b0;
    check_illegal(tbl_ill[i]);  // Cycle N+1
    @(posedge fw_clk_100);
    #1;
    check_illegal(1'b0);  // One cycle only
    if (tbl_wr[i]) model_apply(tbl_cmd[i].op, tbl_cmd[i].payload.static_val);
    @(posedge fw_clk_100);
    #1;
    sw_read_sel = tbl_sel[i];
    @(posedge fw_clk_100);
    #1;
    check_read(tbl_exp[i]);
    check_outputs();
    report_test($sformatf("%0d op %h sel %0d/%0d", i, tbl_cmd[i].op, tbl_sel[i].target,
                          tbl_sel[i].idx), errs_before);
  endtask

  task automatic send_cmd(input logic [7:0] op, input logic [23:0] pl);
    sw_write32_0.op                 = com_config_pkg::op_code_e'(op);
    sw_write32_0.payload.static_val = pl;
    sw_write_strobe                 = 1'b1;
    model_apply(op, pl);
    @(posedge fw_clk_100);
    #1;
  endtask

  task automatic read_and_check(input logic [1:0] target, input logic [7:0] idx);
    com_config_pkg::rd_sel_t sel;
    sel.target  = target;
    sel.idx     = idx;
    sw_read_sel = sel;
    @(posedge fw_clk_100);
    #1;
    check_read(model_read(sel));
  endtask

  // Five strobes on consecutive cycles, later writes must win
  task automatic run_burst();
    logic [7:0] idx;
    int         errs_before;
    errs_before = err_cnt;
    idx         = 8'($urandom % DEPTH);
    send_cmd(com_config_pkg::OP_CFG_STATIC_0, 24'($urandom));
    send_cmd(com_config_pkg::OP_CFG_STATIC_0, 24'($urandom));
    send_cmd(com_config_pkg::OP_CFG_ARRAY_1, {idx, 16'($urandom)});
    send_cmd(com_config_pkg::OP_CFG_ARRAY_1, {idx, 16'($urandom)});
    send_cmd(com_config_pkg::OP_CFG_STATIC_1, 24'($urandom));
    sw_write_strobe = 1'b0;
    repeat (2) @(posedge fw_clk_100);  // Last command lands
    #1;
    read_and_check(2'd0, 8'h00);
    read_and_check(2'd1, 8'h00);
    read_and_check(2'd3, idx);
    check_outputs();
    report_test("burst", errs_before);
  endtask

  // --------------------------------------------------
  // Run
  // --------------------------------------------------
  always @(posedge fw_clk_100) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hdc8b8e85));
    sw_write32_0    = '0;
    sw_write_strobe = 1'b0;
    sw_read_sel     = '0;
    model_clear();
    build_table();
    model_clear();  // Replayed entry by entry during the run
    cycle_limit = n_entries * 6 + 200;
    wait (fw_rst_n === 1'b0);
    wait (fw_rst_n === 1'b1);
    @(posedge fw_clk_100);
    #1;
    for (int i = 0; i < n_entries; i++) begin
      run_entry(i);
    end
    run_burst();
    $display("Tests passed %0d, failed %0d, mismatches %0d, assertion failures %0d",
             test_pass, test_fail, err_cnt, dut0.u_checker.fail_cnt);
    if (err_cnt == 0 && dut0.u_checker.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
src/com_config_pkg.sv
src/com_op_decoder.sv
src/com_config_write_regs.sv
src/com_config_read_mux.sv
src/com_config_top.sv
test/tb_clock_gen.sv
test/com_config_checker.sv
test/tb_com_config.sv
